//--- axi_xbar.f
+incdir+source
source/axi_xbar_pkg.sv
source/axi_xbar_ifs.sv
source/axi_request_router.sv
source/axi_slave_arbiter.sv
source/axi_channel_mux.sv
source/axi_xbar.sv
verification/tb_axi_slave_model.sv
verification/tb_axi_xbar.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_xbar
FILELIST  ?= axi_xbar.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_axi_xbar.sv
`include "axi_xbar_macros.svh"

module tb_axi_xbar;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_XACTS = 18;

    logic ACLK;
    logic ARESETn;
    // Manager side indexed by manager number
    logic [1:0][31:0] araddr;
    logic [1:0][3:0]  arlen;
    logic [1:0]       arvalid;
    logic [1:0]       rready;
    wire  [1:0]       arready_m, rvalid_m, rlast_m;
    wire  [1:0][31:0] rdata_m;
    wire  [1:0][1:0]  rresp_m;
    logic [31:0] awaddr, wdata;
    logic [3:0]  awlen, wstrb;
    logic        awvalid, wlast, wvalid, bready;
    wire         awready, wready, bvalid;
    wire  [1:0]  bresp;
    // Subordinate side indexed by subordinate number
    wire [1:0][31:0] s_araddr, s_rdata, s_awaddr, s_wdata;
    wire [1:0][3:0]  s_arlen, s_awlen, s_wstrb;
    wire [1:0][1:0]  s_rresp, s_bresp;
    wire [1:0] s_arvalid, s_arready, s_rlast, s_rvalid, s_rready, s_awvalid, s_awready;
    wire [1:0] s_wlast, s_wvalid, s_wready, s_bvalid, s_bready;

    string       test_name;
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] rd_addr [2];
    int          rd_left [2];
    logic [31:0] wr_addr [4];
    int          wr_len [4];

    axi_xbar u_dut (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .ARADDR_M0(araddr[0]), .ARADDR_M1(araddr[1]), .ARLEN_M0(arlen[0]), .ARLEN_M1(arlen[1]),
        .ARVALID_M0(arvalid[0]), .ARVALID_M1(arvalid[1]),
        .ARREADY_M0(arready_m[0]), .ARREADY_M1(arready_m[1]),
        .RDATA_M0(rdata_m[0]), .RDATA_M1(rdata_m[1]), .RRESP_M0(rresp_m[0]), .RRESP_M1(rresp_m[1]),
        .RLAST_M0(rlast_m[0]), .RLAST_M1(rlast_m[1]), .RVALID_M0(rvalid_m[0]),
        .RVALID_M1(rvalid_m[1]), .RREADY_M0(rready[0]), .RREADY_M1(rready[1]),
        .AWADDR_M1(awaddr), .AWLEN_M1(awlen), .AWVALID_M1(awvalid), .AWREADY_M1(awready),
        .WDATA_M1(wdata), .WSTRB_M1(wstrb), .WLAST_M1(wlast), .WVALID_M1(wvalid),
        .WREADY_M1(wready), .BRESP_M1(bresp), .BVALID_M1(bvalid), .BREADY_M1(bready),
        .ARADDR_S0(s_araddr[0]), .ARADDR_S1(s_araddr[1]), .ARLEN_S0(s_arlen[0]),
        .ARLEN_S1(s_arlen[1]), .ARVALID_S0(s_arvalid[0]), .ARVALID_S1(s_arvalid[1]),
        .ARREADY_S0(s_arready[0]), .ARREADY_S1(s_arready[1]),
        .RDATA_S0(s_rdata[0]), .RDATA_S1(s_rdata[1]), .RRESP_S0(s_rresp[0]), .RRESP_S1(s_rresp[1]),
        .RLAST_S0(s_rlast[0]), .RLAST_S1(s_rlast[1]), .RVALID_S0(s_rvalid[0]),
        .RVALID_S1(s_rvalid[1]), .RREADY_S0(s_rready[0]), .RREADY_S1(s_rready[1]),
        .AWADDR_S0(s_awaddr[0]), .AWADDR_S1(s_awaddr[1]), .AWLEN_S0(s_awlen[0]),
        .AWLEN_S1(s_awlen[1]), .AWVALID_S0(s_awvalid[0]), .AWVALID_S1(s_awvalid[1]),
        .AWREADY_S0(s_awready[0]), .AWREADY_S1(s_awready[1]),
        .WDATA_S0(s_wdata[0]), .WDATA_S1(s_wdata[1]), .WSTRB_S0(s_wstrb[0]), .WSTRB_S1(s_wstrb[1]),
        .WLAST_S0(s_wlast[0]), .WLAST_S1(s_wlast[1]), .WVALID_S0(s_wvalid[0]),
        .WVALID_S1(s_wvalid[1]), .WREADY_S0(s_wready[0]), .WREADY_S1(s_wready[1]),
        .BRESP_S0(s_bresp[0]), .BRESP_S1(s_bresp[1]), .BVALID_S0(s_bvalid[0]),
        .BVALID_S1(s_bvalid[1]), .BREADY_S0(s_bready[0]), .BREADY_S1(s_bready[1])
    );

    // One memory model per address window
    for (genvar s = 0; s < 2; s++) begin : g_sub
        tb_axi_slave_model u_sub (
            .ACLK(ACLK), .ARESETn(ARESETn),
            .araddr(s_araddr[s]), .arlen(s_arlen[s]), .arvalid(s_arvalid[s]),
            .arready(s_arready[s]), .rdata(s_rdata[s]), .rresp(s_rresp[s]),
            .rlast(s_rlast[s]), .rvalid(s_rvalid[s]), .rready(s_rready[s]),
            .awaddr(s_awaddr[s]), .awvalid(s_awvalid[s]),
            .awready(s_awready[s]), .wdata(s_wdata[s]), .wstrb(s_wstrb[s]),
            .wlast(s_wlast[s]), .wvalid(s_wvalid[s]), .wready(s_wready[s]),
            .bresp(s_bresp[s]), .bvalid(s_bvalid[s]), .bready(s_bready[s])
        );
    end

    initial begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    // Expected word is the last written value or the inverted byte address
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : ~a;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_idle();
        check({test_name, " idle"}, 32'd0, 32'({arready_m, rvalid_m, awready, wready, bvalid,
              s_arvalid, s_rready, s_awvalid, s_wvalid, s_bready}));
    endtask

    task automatic read_burst(input int m, input logic [31:0] a, input int len, input bit stall);
        bit done;
        araddr[m]  <= a;
        arlen[m]   <= 4'(len);
        arvalid[m] <= 1'b1;
        do @(posedge ACLK); while (!arready_m[m]);
        arvalid[m] <= 1'b0;
        done = 1'b0;
        while (!done) begin
            rready[m] <= stall ? ($urandom_range(0, 3) != 0) : 1'b1;
            @(posedge ACLK);
            done = rvalid_m[m] && rready[m] && rlast_m[m];
        end
        rready[m] <= 1'b0;
    endtask

    task automatic write_burst(input logic [31:0] a, input int len, input bit stall);
        logic [31:0] d;
        logic [31:0] w;
        logic [3:0]  st;
        bit          done;
        awaddr  <= a;
        awlen   <= 4'(len);
        awvalid <= 1'b1;
        do @(posedge ACLK); while (!awready);
        awvalid <= 1'b0;
        for (int i = 0; i <= len; i++) begin
            d = $urandom;
            st = 4'($urandom);
            wdata  <= d;
            wstrb  <= st;
            wlast  <= (i == len);
            wvalid <= 1'b1;
            do @(posedge ACLK); while (!wready);
            // Shadow follows the strobe merge
            w = expected_word(a + 32'(4 * i));
            for (int b = 0; b < 4; b++) begin
                if (st[b]) w[8*b +: 8] = d[8*b +: 8];
            end
            shadow[a + 32'(4 * i)] = w;
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        done = 1'b0;
        while (!done) begin
            bready <= stall ? ($urandom_range(0, 1) != 0) : 1'b1;
            @(posedge ACLK);
            done = bvalid && bready;
        end
        check({test_name, " bresp"}, 32'(`AXI_RESP_OKAY), 32'(bresp));
        bready <= 1'b0;
    endtask

    // Each manager's read burst is tracked from its AR handshake
    always @(posedge ACLK) begin
        for (int m = 0; m < 2; m++) begin
            if (arvalid[m] && arready_m[m]) begin
                rd_addr[m] = araddr[m];
                rd_left[m] = 32'(arlen[m]);
            end
            if (rvalid_m[m] && rready[m]) begin
                check({test_name, " rdata"}, expected_word(rd_addr[m]), rdata_m[m]);
                check({test_name, " rlast"}, 32'(rd_left[m] == 0), 32'(rlast_m[m]));
                check({test_name, " rresp"}, 32'(`AXI_RESP_OKAY), 32'(rresp_m[m]));
                rd_addr[m] = rd_addr[m] + 32'd4;
                rd_left[m] = rd_left[m] - 1;
            end
        end
    end

    // Write address and length as the subordinate accepts them
    always @(posedge ACLK) begin
        for (int s = 0; s < 2; s++) begin
            if (s_awvalid[s] && s_awready[s]) begin
                check({test_name, " aw window"}, 32'(awaddr >= `S1_START_ADDR), 32'(s));
                check({test_name, " awaddr"}, awaddr, s_awaddr[s]);
                check({test_name, " awlen"}, 32'(awlen), 32'(s_awlen[s]));
            end
        end
    end

    initial begin
        repeat (8 + NUM_XACTS * 200) @(posedge ACLK);
        $display("Run timed out before all transactions finished");
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        void'($urandom(11));
        ARESETn = 1'b0;
        araddr = '0;
        arlen = '0;
        arvalid = '0;
        rready = '0;
        awaddr = '0;
        awlen = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        test_name = "reset";
        repeat (8) begin
            @(posedge ACLK);
            check_idle();
        end
        ARESETn <= 1'b1;
        repeat (2) begin
            @(posedge ACLK);
            check_idle();
        end

        test_name = "m0_read";
        read_burst(0, 32'h0000_0100, 0, 1'b0);
        read_burst(0, 32'h0000_0200, 3, 1'b0);
        read_burst(0, 32'h0001_0100, 0, 1'b0);
        read_burst(0, 32'h0001_0200, 3, 1'b0);

        test_name = "m1_write";
        for (int w = 0; w < 4; w++) begin
            wr_addr[w] = (w < 2 ? 32'h0000_0400 : 32'h0001_0400) + 32'(32 * w);
            wr_len[w] = $urandom_range(0, 3);
            write_burst(wr_addr[w], wr_len[w], 1'b0);
        end
        // Readback alternates between the managers
        for (int w = 0; w < 4; w++) begin
            read_burst(w % 2, wr_addr[w], wr_len[w], 1'b0);
        end

        test_name = "same_slave";
        fork
            read_burst(0, 32'h0000_0800, 3, 1'b1);
            read_burst(1, 32'h0000_0900, 3, 1'b1);
        join

        test_name = "mixed";
        fork
            read_burst(0, 32'h0000_0A00, 3, 1'b1);
            write_burst(32'h0001_0A00, 3, 1'b1);
        join
        read_burst(1, 32'h0001_0A00, 3, 1'b0);
        read_burst(0, 32'h0000_0A00, 0, 1'b0);

        repeat (2) @(posedge ACLK);
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- verification/tb_axi_slave_model.sv
`include "axi_xbar_macros.svh"

module tb_axi_slave_model (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic [`AXI_ADDR_BITS-1:0] araddr,
    input  logic [`AXI_LEN_BITS-1:0]  arlen,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`AXI_DATA_BITS-1:0] rdata,
    output logic [`AXI_RESP_BITS-1:0] rresp,
    output logic                      rlast,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic [`AXI_ADDR_BITS-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXI_DATA_BITS-1:0] wdata,
    input  logic [`AXI_STRB_BITS-1:0] wstrb,
    input  logic                      wlast,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [`AXI_RESP_BITS-1:0] bresp,
    output logic                      bvalid,
    input  logic                      bready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Sparse storage where untouched words read as the inverted byte address
    logic [`AXI_DATA_BITS-1:0] mem [logic [`AXI_ADDR_BITS-1:0]];

    function automatic logic [`AXI_DATA_BITS-1:0] read_word(input logic [`AXI_ADDR_BITS-1:0] a);
        return mem.exists(a) ? mem[a] : ~a;
    endfunction

    initial begin
        logic [`AXI_ADDR_BITS-1:0] a;
        logic [`AXI_DATA_BITS-1:0] w;
        int n;
        arready = 1'b0;
        rdata   = '0;
        rresp   = `AXI_RESP_OKAY;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bresp   = `AXI_RESP_OKAY;
        bvalid  = 1'b0;
        wait (ARESETn === 1'b1);
        forever begin
            @(posedge ACLK);
            if (arvalid) begin
                repeat ($urandom_range(0, 3)) @(posedge ACLK);
                arready <= 1'b1;
                a = araddr;
                n = 32'(arlen);
                @(posedge ACLK);
                arready <= 1'b0;
                // Incrementing burst
                for (int i = 0; i <= n; i++) begin
                    rvalid <= 1'b1;
                    rdata  <= read_word(a);
                    rresp  <= `AXI_RESP_OKAY;
                    rlast  <= (i == n);
                    do @(posedge ACLK); while (!rready);
                    a = a + 32'd4;
                end
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                rdata  <= '0;
            end else if (awvalid) begin
                repeat ($urandom_range(0, 3)) @(posedge ACLK);
                awready <= 1'b1;
                a = awaddr;
                @(posedge ACLK);
                awready <= 1'b0;
                wready  <= 1'b1;
                do begin
                    @(posedge ACLK);
                    if (wvalid) begin
                        w = read_word(a);
                        for (int b = 0; b < `AXI_STRB_BITS; b++) begin
                            if (wstrb[b]) w[8*b +: 8] = wdata[8*b +: 8];
                        end
                        mem[a] = w;
                        a = a + 32'd4;
                    end
                end while (!(wvalid && wlast));
                wready <= 1'b0;
                // Response after a short random delay
                repeat ($urandom_range(0, 3)) @(posedge ACLK);
                bvalid <= 1'b1;
                bresp  <= `AXI_RESP_OKAY;
                do @(posedge ACLK); while (!bready);
                bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- source/axi_xbar.sv
`include "axi_xbar_macros.svh"

module axi_xbar (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    // Manager read paths
    input  logic [`AXI_ADDR_BITS-1:0] ARADDR_M0, ARADDR_M1,
    input  logic [`AXI_LEN_BITS-1:0]  ARLEN_M0, ARLEN_M1,
    input  logic                      ARVALID_M0, ARVALID_M1,
    output logic                      ARREADY_M0, ARREADY_M1,
    output logic [`AXI_DATA_BITS-1:0] RDATA_M0, RDATA_M1,
    output logic [`AXI_RESP_BITS-1:0] RRESP_M0, RRESP_M1,
    output logic                      RLAST_M0, RLAST_M1,
    output logic                      RVALID_M0, RVALID_M1,
    input  logic                      RREADY_M0, RREADY_M1,
    // Manager 1 write path
    input  logic [`AXI_ADDR_BITS-1:0] AWADDR_M1,
    input  logic [`AXI_LEN_BITS-1:0]  AWLEN_M1,
    input  logic                      AWVALID_M1,
    output logic                      AWREADY_M1,
    input  logic [`AXI_DATA_BITS-1:0] WDATA_M1,
    input  logic [`AXI_STRB_BITS-1:0] WSTRB_M1,
    input  logic                      WLAST_M1, WVALID_M1,
    output logic                      WREADY_M1,
    output logic [`AXI_RESP_BITS-1:0] BRESP_M1,
    output logic                      BVALID_M1,
    input  logic                      BREADY_M1,
    // Subordinate read paths
    output logic [`AXI_ADDR_BITS-1:0] ARADDR_S0, ARADDR_S1,
    output logic [`AXI_LEN_BITS-1:0]  ARLEN_S0, ARLEN_S1,
    output logic                      ARVALID_S0, ARVALID_S1,
    input  logic                      ARREADY_S0, ARREADY_S1,
    input  logic [`AXI_DATA_BITS-1:0] RDATA_S0, RDATA_S1,
    input  logic [`AXI_RESP_BITS-1:0] RRESP_S0, RRESP_S1,
    input  logic                      RLAST_S0, RLAST_S1,
    input  logic                      RVALID_S0, RVALID_S1,
    output logic                      RREADY_S0, RREADY_S1,
    // Subordinate write paths
    output logic [`AXI_ADDR_BITS-1:0] AWADDR_S0, AWADDR_S1,
    output logic [`AXI_LEN_BITS-1:0]  AWLEN_S0, AWLEN_S1,
    output logic                      AWVALID_S0, AWVALID_S1,
    input  logic                      AWREADY_S0, AWREADY_S1,
    output logic [`AXI_DATA_BITS-1:0] WDATA_S0, WDATA_S1,
    output logic [`AXI_STRB_BITS-1:0] WSTRB_S0, WSTRB_S1,
    output logic                      WLAST_S0, WLAST_S1,
    output logic                      WVALID_S0, WVALID_S1,
    input  logic                      WREADY_S0, WREADY_S1,
    input  logic [`AXI_RESP_BITS-1:0] BRESP_S0, BRESP_S1,
    input  logic                      BVALID_S0, BVALID_S1,
    output logic                      BREADY_S0, BREADY_S1
);

    axi_rd_if m0_rd ();
    axi_rd_if m1_rd ();
    axi_wr_if m1_wr ();
    axi_rd_if s0_rd ();
    axi_wr_if s0_wr ();
    axi_rd_if s1_rd ();
    axi_wr_if s1_wr ();

    logic                        s0_req_valid;
    axi_xbar_pkg::xfer_kind_t    s0_req_kind;
    axi_xbar_pkg::manager_id_t   s0_req_owner;
    logic                        s1_req_valid;
    axi_xbar_pkg::xfer_kind_t    s1_req_kind;
    axi_xbar_pkg::manager_id_t   s1_req_owner;
    axi_xbar_pkg::slave_status_t s0_status;
    axi_xbar_pkg::slave_status_t s1_status;

    // ----------------------------------------
    // Manager side bundles
    // ----------------------------------------
    assign {m0_rd.araddr, m0_rd.arlen, m0_rd.arvalid, m0_rd.rready} =
        {ARADDR_M0, ARLEN_M0, ARVALID_M0, RREADY_M0};
    assign {ARREADY_M0, RDATA_M0, RRESP_M0, RLAST_M0, RVALID_M0} =
        {m0_rd.arready, m0_rd.rdata, m0_rd.rresp, m0_rd.rlast, m0_rd.rvalid};
    assign {m1_rd.araddr, m1_rd.arlen, m1_rd.arvalid, m1_rd.rready} =
        {ARADDR_M1, ARLEN_M1, ARVALID_M1, RREADY_M1};
    assign {ARREADY_M1, RDATA_M1, RRESP_M1, RLAST_M1, RVALID_M1} =
        {m1_rd.arready, m1_rd.rdata, m1_rd.rresp, m1_rd.rlast, m1_rd.rvalid};
    assign {m1_wr.awaddr, m1_wr.awlen, m1_wr.awvalid, m1_wr.wdata, m1_wr.wstrb,
            m1_wr.wlast, m1_wr.wvalid, m1_wr.bready} =
        {AWADDR_M1, AWLEN_M1, AWVALID_M1, WDATA_M1, WSTRB_M1, WLAST_M1, WVALID_M1, BREADY_M1};
    assign {AWREADY_M1, WREADY_M1, BRESP_M1, BVALID_M1} =
        {m1_wr.awready, m1_wr.wready, m1_wr.bresp, m1_wr.bvalid};

    // ----------------------------------------
    // Subordinate side bundles
    // ----------------------------------------
    assign {ARADDR_S0, ARLEN_S0, ARVALID_S0, RREADY_S0} =
        {s0_rd.araddr, s0_rd.arlen, s0_rd.arvalid, s0_rd.rready};
    assign {s0_rd.arready, s0_rd.rdata, s0_rd.rresp, s0_rd.rlast, s0_rd.rvalid} =
        {ARREADY_S0, RDATA_S0, RRESP_S0, RLAST_S0, RVALID_S0};
    assign {ARADDR_S1, ARLEN_S1, ARVALID_S1, RREADY_S1} =
        {s1_rd.araddr, s1_rd.arlen, s1_rd.arvalid, s1_rd.rready};
    assign {s1_rd.arready, s1_rd.rdata, s1_rd.rresp, s1_rd.rlast, s1_rd.rvalid} =
        {ARREADY_S1, RDATA_S1, RRESP_S1, RLAST_S1, RVALID_S1};
    assign {AWADDR_S0, AWLEN_S0, AWVALID_S0, WDATA_S0, WSTRB_S0, WLAST_S0, WVALID_S0, BREADY_S0} =
        {s0_wr.awaddr, s0_wr.awlen, s0_wr.awvalid, s0_wr.wdata, s0_wr.wstrb,
         s0_wr.wlast, s0_wr.wvalid, s0_wr.bready};
    assign {s0_wr.awready, s0_wr.wready, s0_wr.bresp, s0_wr.bvalid} =
        {AWREADY_S0, WREADY_S0, BRESP_S0, BVALID_S0};
    assign {AWADDR_S1, AWLEN_S1, AWVALID_S1, WDATA_S1, WSTRB_S1, WLAST_S1, WVALID_S1, BREADY_S1} =
        {s1_wr.awaddr, s1_wr.awlen, s1_wr.awvalid, s1_wr.wdata, s1_wr.wstrb,
         s1_wr.wlast, s1_wr.wvalid, s1_wr.bready};
    assign {s1_wr.awready, s1_wr.wready, s1_wr.bresp, s1_wr.bvalid} =
        {AWREADY_S1, WREADY_S1, BRESP_S1, BVALID_S1};

    axi_request_router u_router (
        .ACLK         (ACLK),
        .ARESETn      (ARESETn),
        .m0_araddr    (m0_rd.araddr),
        .m0_arvalid   (m0_rd.arvalid),
        .m1_araddr    (m1_rd.araddr),
        .m1_arvalid   (m1_rd.arvalid),
        .m1_awaddr    (m1_wr.awaddr),
        .m1_awvalid   (m1_wr.awvalid),
        .s0_req_valid (s0_req_valid),
        .s0_req_kind  (s0_req_kind),
        .s0_req_owner (s0_req_owner),
        .s1_req_valid (s1_req_valid),
        .s1_req_kind  (s1_req_kind),
        .s1_req_owner (s1_req_owner)
    );

    // One status record per subordinate
    axi_slave_arbiter u_s0_arbiter (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req_valid (s0_req_valid),
        .req_kind  (s0_req_kind),
        .req_owner (s0_req_owner),
        .rvalid    (s0_rd.rvalid),
        .rready    (s0_rd.rready),
        .rlast     (s0_rd.rlast),
        .bvalid    (s0_wr.bvalid),
        .bready    (s0_wr.bready),
        .status    (s0_status)
    );

    axi_slave_arbiter u_s1_arbiter (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req_valid (s1_req_valid),
        .req_kind  (s1_req_kind),
        .req_owner (s1_req_owner),
        .rvalid    (s1_rd.rvalid),
        .rready    (s1_rd.rready),
        .rlast     (s1_rd.rlast),
        .bvalid    (s1_wr.bvalid),
        .bready    (s1_wr.bready),
        .status    (s1_status)
    );

    axi_channel_mux u_mux (
        .s0_status (s0_status),
        .s1_status (s1_status),
        .m0_rd     (m0_rd),
        .m1_rd     (m1_rd),
        .m1_wr     (m1_wr),
        .s0_rd     (s0_rd),
        .s0_wr     (s0_wr),
        .s1_rd     (s1_rd),
        .s1_wr     (s1_wr)
    );

endmodule

//--- source/axi_channel_mux.sv
`include "axi_xbar_macros.svh"

module axi_channel_mux (
    input  axi_xbar_pkg::slave_status_t s0_status,
    input  axi_xbar_pkg::slave_status_t s1_status,
    axi_rd_if.sub                       m0_rd,
    axi_rd_if.sub                       m1_rd,
    axi_wr_if.sub                       m1_wr,
    axi_rd_if.mgr                       s0_rd,
    axi_wr_if.mgr                       s0_wr,
    axi_rd_if.mgr                       s1_rd,
    axi_wr_if.mgr                       s1_wr
);

    logic s0_m0_rd;
    logic s0_m1_rd;
    logic s0_m1_wr;
    logic s1_m0_rd;
    logic s1_m1_rd;
    logic s1_m1_wr;

    // Path selects from the status records
    assign s0_m0_rd = s0_status.busy && s0_status.kind == axi_xbar_pkg::READ
                      && s0_status.owner == axi_xbar_pkg::M0;
    assign s0_m1_rd = s0_status.busy && s0_status.kind == axi_xbar_pkg::READ
                      && s0_status.owner == axi_xbar_pkg::M1;
    assign s0_m1_wr = s0_status.busy && s0_status.kind == axi_xbar_pkg::WRITE
                      && s0_status.owner == axi_xbar_pkg::M1;
    assign s1_m0_rd = s1_status.busy && s1_status.kind == axi_xbar_pkg::READ
                      && s1_status.owner == axi_xbar_pkg::M0;
    assign s1_m1_rd = s1_status.busy && s1_status.kind == axi_xbar_pkg::READ
                      && s1_status.owner == axi_xbar_pkg::M1;
    assign s1_m1_wr = s1_status.busy && s1_status.kind == axi_xbar_pkg::WRITE
                      && s1_status.owner == axi_xbar_pkg::M1;

    // ----------------------------------------
    // Towards the subordinates
    // ----------------------------------------
    assign s0_rd.araddr  = s0_m0_rd ? m0_rd.araddr  : s0_m1_rd ? m1_rd.araddr  : '0;
    assign s0_rd.arlen   = s0_m0_rd ? m0_rd.arlen   : s0_m1_rd ? m1_rd.arlen   : '0;
    assign s0_rd.arvalid = s0_m0_rd ? m0_rd.arvalid : s0_m1_rd ? m1_rd.arvalid : 1'b0;
    assign s0_rd.rready  = s0_m0_rd ? m0_rd.rready  : s0_m1_rd ? m1_rd.rready  : 1'b0;
    assign s1_rd.araddr  = s1_m0_rd ? m0_rd.araddr  : s1_m1_rd ? m1_rd.araddr  : '0;
    assign s1_rd.arlen   = s1_m0_rd ? m0_rd.arlen   : s1_m1_rd ? m1_rd.arlen   : '0;
    assign s1_rd.arvalid = s1_m0_rd ? m0_rd.arvalid : s1_m1_rd ? m1_rd.arvalid : 1'b0;
    assign s1_rd.rready  = s1_m0_rd ? m0_rd.rready  : s1_m1_rd ? m1_rd.rready  : 1'b0;

    // Only manager 1 writes
    assign s0_wr.awaddr  = s0_m1_wr ? m1_wr.awaddr  : '0;
    assign s0_wr.awlen   = s0_m1_wr ? m1_wr.awlen   : '0;
    assign s0_wr.awvalid = s0_m1_wr ? m1_wr.awvalid : 1'b0;
    assign s0_wr.wdata   = s0_m1_wr ? m1_wr.wdata   : '0;
    assign s0_wr.wstrb   = s0_m1_wr ? m1_wr.wstrb   : '0;
    assign s0_wr.wlast   = s0_m1_wr ? m1_wr.wlast   : 1'b0;
    assign s0_wr.wvalid  = s0_m1_wr ? m1_wr.wvalid  : 1'b0;
    assign s0_wr.bready  = s0_m1_wr ? m1_wr.bready  : 1'b0;
    assign s1_wr.awaddr  = s1_m1_wr ? m1_wr.awaddr  : '0;
    assign s1_wr.awlen   = s1_m1_wr ? m1_wr.awlen   : '0;
    assign s1_wr.awvalid = s1_m1_wr ? m1_wr.awvalid : 1'b0;
    assign s1_wr.wdata   = s1_m1_wr ? m1_wr.wdata   : '0;
    assign s1_wr.wstrb   = s1_m1_wr ? m1_wr.wstrb   : '0;
    assign s1_wr.wlast   = s1_m1_wr ? m1_wr.wlast   : 1'b0;
    assign s1_wr.wvalid  = s1_m1_wr ? m1_wr.wvalid  : 1'b0;
    assign s1_wr.bready  = s1_m1_wr ? m1_wr.bready  : 1'b0;

    // ----------------------------------------
    // Back to the managers
    // ----------------------------------------
    assign m0_rd.arready = s0_m0_rd ? s0_rd.arready : s1_m0_rd ? s1_rd.arready : 1'b0;
    assign m0_rd.rdata   = s0_m0_rd ? s0_rd.rdata   : s1_m0_rd ? s1_rd.rdata   : '0;
    assign m0_rd.rresp   = s0_m0_rd ? s0_rd.rresp   : s1_m0_rd ? s1_rd.rresp   : `AXI_RESP_OKAY;
    assign m0_rd.rlast   = s0_m0_rd ? s0_rd.rlast   : s1_m0_rd ? s1_rd.rlast   : 1'b0;
    assign m0_rd.rvalid  = s0_m0_rd ? s0_rd.rvalid  : s1_m0_rd ? s1_rd.rvalid  : 1'b0;
    assign m1_rd.arready = s0_m1_rd ? s0_rd.arready : s1_m1_rd ? s1_rd.arready : 1'b0;
    assign m1_rd.rdata   = s0_m1_rd ? s0_rd.rdata   : s1_m1_rd ? s1_rd.rdata   : '0;
    assign m1_rd.rresp   = s0_m1_rd ? s0_rd.rresp   : s1_m1_rd ? s1_rd.rresp   : `AXI_RESP_OKAY;
    assign m1_rd.rlast   = s0_m1_rd ? s0_rd.rlast   : s1_m1_rd ? s1_rd.rlast   : 1'b0;
    assign m1_rd.rvalid  = s0_m1_rd ? s0_rd.rvalid  : s1_m1_rd ? s1_rd.rvalid  : 1'b0;

    assign m1_wr.awready = s0_m1_wr ? s0_wr.awready : s1_m1_wr ? s1_wr.awready : 1'b0;
    assign m1_wr.wready  = s0_m1_wr ? s0_wr.wready  : s1_m1_wr ? s1_wr.wready  : 1'b0;
    assign m1_wr.bresp   = s0_m1_wr ? s0_wr.bresp   : s1_m1_wr ? s1_wr.bresp   : `AXI_RESP_OKAY;
    assign m1_wr.bvalid  = s0_m1_wr ? s0_wr.bvalid  : s1_m1_wr ? s1_wr.bvalid  : 1'b0;

endmodule

//--- source/axi_slave_arbiter.sv
module axi_slave_arbiter (
    input  logic                        ACLK,
    input  logic                        ARESETn,
    input  logic                        req_valid,
    input  axi_xbar_pkg::xfer_kind_t    req_kind,
    input  axi_xbar_pkg::manager_id_t   req_owner,
    input  logic                        rvalid,
    input  logic                        rready,
    input  logic                        rlast,
    input  logic                        bvalid,
    input  logic                        bready,
    output axi_xbar_pkg::slave_status_t status
);

    logic rd_done;
    logic wr_done;
    logic done;

    // Last read beat taken, or write response taken
    assign rd_done = rvalid && rready && rlast;
    assign wr_done = bvalid && bready;
    assign done    = (status.kind == axi_xbar_pkg::READ) ? rd_done : wr_done;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            status <= '0;
        end else if (status.busy) begin
            // Held until the granted transfer finishes
            if (done) begin
                status.busy <= 1'b0;
            end
        end else if (req_valid) begin
            status.busy  <= 1'b1;
            status.kind  <= req_kind;
            status.owner <= req_owner;
        end
    end

endmodule

//--- source/axi_request_router.sv
`include "axi_xbar_macros.svh"

module axi_request_router (
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic [`AXI_ADDR_BITS-1:0] m0_araddr,
    input  logic                      m0_arvalid,
    input  logic [`AXI_ADDR_BITS-1:0] m1_araddr,
    input  logic                      m1_arvalid,
    input  logic [`AXI_ADDR_BITS-1:0] m1_awaddr,
    input  logic                      m1_awvalid,
    output logic                      s0_req_valid,
    output axi_xbar_pkg::xfer_kind_t  s0_req_kind,
    output axi_xbar_pkg::manager_id_t s0_req_owner,
    output logic                      s1_req_valid,
    output axi_xbar_pkg::xfer_kind_t  s1_req_kind,
    output axi_xbar_pkg::manager_id_t s1_req_owner
);

    axi_xbar_pkg::manager_id_t prio;
    axi_xbar_pkg::slave_id_t   m0_ar_dst;
    axi_xbar_pkg::slave_id_t   m1_ar_dst;
    axi_xbar_pkg::slave_id_t   m1_aw_dst;
    axi_xbar_pkg::slave_id_t   rd_dst;
    axi_xbar_pkg::slave_id_t   wr_dst;

    // Idle or unmapped requests decode to NONE
    function automatic axi_xbar_pkg::slave_id_t decode(
        input logic [`AXI_ADDR_BITS-1:0] addr,
        input logic                      valid
    );
        if (valid && addr >= `S0_START_ADDR && addr <= `S0_END_ADDR)
            return axi_xbar_pkg::S0;
        if (valid && addr >= `S1_START_ADDR && addr <= `S1_END_ADDR)
            return axi_xbar_pkg::S1;
        return axi_xbar_pkg::NONE;
    endfunction

    assign m0_ar_dst = decode(m0_araddr, m0_arvalid);
    assign m1_ar_dst = decode(m1_araddr, m1_arvalid);
    assign m1_aw_dst = decode(m1_awaddr, m1_awvalid);

    // Manager priority flips every cycle
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            prio <= axi_xbar_pkg::M0;
        end else begin
            prio <= (prio == axi_xbar_pkg::M0) ? axi_xbar_pkg::M1 : axi_xbar_pkg::M0;
        end
    end

    // Only the prioritized manager is presented; M0 has no write path
    assign rd_dst = (prio == axi_xbar_pkg::M0) ? m0_ar_dst : m1_ar_dst;
    assign wr_dst = (prio == axi_xbar_pkg::M1) ? m1_aw_dst : axi_xbar_pkg::NONE;

    // A write to the same subordinate beats the read
    assign s0_req_valid = (rd_dst == axi_xbar_pkg::S0) || (wr_dst == axi_xbar_pkg::S0);
    assign s0_req_kind  = (wr_dst == axi_xbar_pkg::S0) ? axi_xbar_pkg::WRITE : axi_xbar_pkg::READ;
    assign s0_req_owner = prio;
    assign s1_req_valid = (rd_dst == axi_xbar_pkg::S1) || (wr_dst == axi_xbar_pkg::S1);
    assign s1_req_kind  = (wr_dst == axi_xbar_pkg::S1) ? axi_xbar_pkg::WRITE : axi_xbar_pkg::READ;
    assign s1_req_owner = prio;

endmodule

//--- source/axi_xbar_ifs.sv
`include "axi_xbar_macros.svh"

// AR and R channels of one path
interface axi_rd_if;
    logic [`AXI_ADDR_BITS-1:0] araddr;
    logic [`AXI_LEN_BITS-1:0]  arlen;
    logic                      arvalid;
    logic                      arready;
    logic [`AXI_DATA_BITS-1:0] rdata;
    logic [`AXI_RESP_BITS-1:0] rresp;
    logic                      rlast;
    logic                      rvalid;
    logic                      rready;

    modport mgr (
        output araddr, arlen, arvalid, rready,
        input  arready, rdata, rresp, rlast, rvalid
    );
    modport sub (
        input  araddr, arlen, arvalid, rready,
        output arready, rdata, rresp, rlast, rvalid
    );
endinterface

// AW, W and B channels of one path
interface axi_wr_if;
    logic [`AXI_ADDR_BITS-1:0] awaddr;
    logic [`AXI_LEN_BITS-1:0]  awlen;
    logic                      awvalid;
    logic                      awready;
    logic [`AXI_DATA_BITS-1:0] wdata;
    logic [`AXI_STRB_BITS-1:0] wstrb;
    logic                      wlast;
    logic                      wvalid;
    logic                      wready;
    logic [`AXI_RESP_BITS-1:0] bresp;
    logic                      bvalid;
    logic                      bready;

    modport mgr (
        output awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
        input  awready, wready, bresp, bvalid
    );
    modport sub (
        input  awaddr, awlen, awvalid, wdata, wstrb, wlast, wvalid, bready,
        output awready, wready, bresp, bvalid
    );
endinterface

//--- source/axi_xbar_pkg.sv
package axi_xbar_pkg;

    // Requesting manager
    typedef enum logic {
        M0,
        M1
    } manager_id_t;

    // Address decode result
    typedef enum logic [1:0] {
        S0,
        S1,
        NONE
    } slave_id_t;

    typedef enum logic {
        READ,
        WRITE
    } xfer_kind_t;

    // Ownership record, one per subordinate
    typedef struct packed {
        logic        busy;
        xfer_kind_t  kind;
        manager_id_t owner;
    } slave_status_t;

endpackage

//--- source/axi_xbar_macros.svh
`ifndef AXI_XBAR_MACROS_SVH
`define AXI_XBAR_MACROS_SVH

// Bus widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4
// Beats per burst minus one
`define AXI_LEN_BITS  4
`define AXI_RESP_BITS 2

// Response codes
`define AXI_RESP_OKAY 2'b00

// ----------------------------------------
// One address window per subordinate
// ----------------------------------------
`define S0_START_ADDR 32'h0000_0000
`define S0_END_ADDR   32'h0000_FFFF
`define S1_START_ADDR 32'h0001_0000
`define S1_END_ADDR   32'h0001_FFFF

`endif
